//--- flist.f
rtl/eth_pkg.sv
rtl/payload_buf.sv
rtl/eth_fcs.sv
rtl/arp_tx.sv
rtl/ip_tx.sv
rtl/mac_tx.sv
rtl/eth_tx_top.sv
bench/eth_tx_tb.sv

//--- Makefile
# Verilator build and run for the Ethernet transmit path.

TOP      ?= eth_tx_tb
FLIST    ?= flist.f
OBJ_DIR  ?= obj_dir
VERILATOR ?= verilator
VFLAGS   ?= --binary --timing --assert -j 0
PASS_MSG ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF -e "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/eth_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    // seven frames of at most 130 cycles, three buffer fills of 65 cycles and margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk;
    logic                  rst;
    logic                  fs;
    eth_pkg::ether_type_t  frame_type;
    eth_pkg::mac_addr_t    dst_mac;
    eth_pkg::mac_addr_t    src_mac;
    eth_pkg::ip_addr_t     src_ip;
    eth_pkg::ip_addr_t     dst_ip;
    eth_pkg::payload_len_t payload_len;
    logic                  wr_en;
    eth_pkg::buf_addr_t    wr_addr;
    eth_pkg::byte_t        wr_data;
    wire                   fd;
    wire                   gmii_tx_en;
    wire eth_pkg::byte_t   gmii_txd;

    eth_pkg::byte_t exp_q[$];   // bytes still expected on the wire.
    eth_pkg::byte_t rx_q[$];
    eth_pkg::byte_t pay_mem [0:eth_pkg::PAYLOAD_MAX-1];
    logic [15:0]    exp_ip_id;
    int             seed;
    int             errors = 0;
    int             checks = 0;
    int             cycles = 0;

    eth_tx_top eth_tx_top_inst (
        .clk         (clk),
        .rst         (rst),
        .fs          (fs),
        .frame_type  (frame_type),
        .dst_mac     (dst_mac),
        .src_mac     (src_mac),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .payload_len (payload_len),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .fd          (fd),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the frame sequence never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        checks++;
        assert (got == want) else begin
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, want, got);
            errors++;
        end
    endtask

    // wire monitor, every byte is matched against the model queue.
    always @(posedge clk) begin
        eth_pkg::byte_t want;
        if (!rst && gmii_tx_en) begin
            rx_q.push_back(gmii_txd);
            assert (exp_q.size() > 0) else begin
                $display("at %0t a byte went out while no frame byte was expected", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                check_value("gmii_txd", 32'(want), 32'(gmii_txd));
            end
        end
    end

    frame_start: assert property (@(posedge clk) disable iff (rst)
        $rose(fs) |-> !gmii_tx_en [*3] ##1 gmii_tx_en)
        else begin
            $display("at %0t the frame did not start on the third edge after fs", $time);
            errors++;
        end

    fd_after_gap: assert property (@(posedge clk) disable iff (rst)
        $fell(gmii_tx_en) |-> !fd [*12] ##1 fd)
        else begin
            $display("at %0t fd did not rise 12 cycles after the frame ended", $time);
            errors++;
        end

    fd_hold: assert property (@(posedge clk) disable iff (rst) fd && fs |=> fd)
        else begin
            $display("at %0t fd dropped while fs was still high", $time);
            errors++;
        end

    fd_release: assert property (@(posedge clk) disable iff (rst) fd && !fs |=> !fd)
        else begin
            $display("at %0t fd stayed high after fs was dropped", $time);
            errors++;
        end

    quiet_in_done: assert property (@(posedge clk) disable iff (rst) fd |-> !gmii_tx_en)
        else begin
            $display("at %0t a frame started while fd was still high", $time);
            errors++;
        end

    task automatic check_idle();
        check_value("gmii_tx_en", 32'd0, 32'(gmii_tx_en));
        check_value("gmii_txd", 32'd0, 32'(gmii_txd));
        check_value("fd", 32'd0, 32'(fd));
    endtask

    task automatic push_field(input logic [47:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_q.push_back(v[8*i +: 8]);   // msb first.
        end
    endtask

    // reflected crc, complemented and sent lsb first.
    task automatic append_fcs();
        eth_pkg::crc_t c;
        c = eth_pkg::CRC_INIT;
        foreach (exp_q[k]) begin
            c = c ^ {24'd0, exp_q[k]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ eth_pkg::CRC_POLY) : (c >> 1);
            end
        end
        c = ~c;
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(c[8*i +: 8]);
        end
    endtask

    function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
        logic [31:0] sum;
        sum = 32'd0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + {16'd0, hdr[16*w +: 16]};
        end
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    task automatic fill_buffer(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            pay_mem[i] = 8'($random(seed));
            wr_en   <= 1'b1;
            wr_addr <= 6'(i);
            wr_data <= pay_mem[i];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic send_frame(input eth_pkg::ether_type_t ftype, input int len,
                              input int hold);
        eth_pkg::mac_addr_t d_mac;
        eth_pkg::mac_addr_t s_mac;
        eth_pkg::ip_addr_t  s_ip;
        eth_pkg::ip_addr_t  d_ip;
        logic [159:0]       hdr;
        logic [31:0]        sum;
        int                 body_len;
        int                 run;
        d_mac = 48'({$random(seed), $random(seed)});
        s_mac = 48'({$random(seed), $random(seed)});
        s_ip = $random(seed);
        d_ip = $random(seed);
        exp_q.delete();
        rx_q.delete();
        push_field(d_mac, 6);
        push_field(s_mac, 6);
        push_field(48'(ftype), 2);
        if (ftype == eth_pkg::ETH_TYPE_ARP) begin
            push_field(48'h0001, 2);
            push_field(48'(eth_pkg::ETH_TYPE_IP), 2);
            push_field(48'h06, 1);
            push_field(48'h04, 1);
            push_field(48'h0001, 2);
            push_field(s_mac, 6);
            push_field(48'(s_ip), 4);
            push_field(48'h0, 6);
            push_field(48'(d_ip), 4);
            body_len = eth_pkg::ARP_LEN;
        end else begin
            fill_buffer(len);
            hdr = {8'h45, 8'h00, 16'(eth_pkg::IP_HDR_LEN + len), exp_ip_id, 16'h0000,
                   eth_pkg::IP_TTL, eth_pkg::IP_PROTO, 16'h0000, s_ip, d_ip};
            hdr[79:64] = ip_checksum(hdr);
            push_field(hdr[159:112], 6);
            push_field(hdr[111:64], 6);
            push_field(hdr[63:16], 6);
            push_field(48'(hdr[15:0]), 2);
            for (int i = 0; i < len; i++) begin
                exp_q.push_back(pay_mem[i]);
            end
            exp_ip_id = exp_ip_id + 16'd1;
            body_len = eth_pkg::IP_HDR_LEN + len;
        end
        append_fcs();
        @(posedge clk);
        frame_type  <= ftype;
        dst_mac     <= d_mac;
        src_mac     <= s_mac;
        src_ip      <= s_ip;
        dst_ip      <= d_ip;
        payload_len <= 7'(len);
        fs          <= 1'b1;
        run = 0;
        @(posedge clk);
        while (!gmii_tx_en) @(posedge clk);
        while (gmii_tx_en) begin
            run++;
            @(posedge clk);
        end
        check_value("gmii_tx_en cycles", 32'(eth_pkg::HDR_LEN + body_len + 4), 32'(run));
        while (!fd) @(posedge clk);
        repeat (hold) @(posedge clk);
        if (hold > 0) begin
            check_value("fd", 32'd1, 32'(fd));
        end
        fs <= 1'b0;
        while (fd) @(posedge clk);
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("at %0t %0d frame bytes never appeared on the wire", $time, exp_q.size());
            errors++;
        end
        // a correct header sums to all ones, checksum included.
        if (ftype != eth_pkg::ETH_TYPE_ARP && rx_q.size() >= 34) begin
            sum = 32'd0;
            for (int w = 0; w < 10; w++) begin
                sum = sum + {16'd0, rx_q[14 + 2*w], rx_q[15 + 2*w]};
            end
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
            check_value("ip header sum", 32'h0000FFFF, {16'd0, sum[15:0]});
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - mark);
        end
    endtask

    initial begin
        int mark;
        int len;
        seed = 32'hcd7f;
        rst = 1'b1;
        fs = 1'b0;
        frame_type = 16'h0000;
        dst_mac = 48'h0;
        src_mac = 48'h0;
        src_ip = 32'h0;
        dst_ip = 32'h0;
        payload_len = 7'd0;
        wr_en = 1'b0;
        wr_addr = 6'd0;
        wr_data = 8'h00;
        exp_ip_id = 16'd0;

        mark = errors;
        @(posedge clk);
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            check_idle();
        end
        rst <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_idle();
        end
        report_test("reset state", mark);

        mark = errors;
        send_frame(eth_pkg::ETH_TYPE_ARP, 0, 0);
        report_test("arp frame", mark);

        mark = errors;
        len = ($random(seed) & 63) + 1;
        send_frame(eth_pkg::ETH_TYPE_IP, len, 0);
        report_test("ip frame", mark);

        mark = errors;
        send_frame(eth_pkg::ETH_TYPE_ARP, 0, 6);   // fs held past fd.
        report_test("fd handshake", mark);

        mark = errors;
        for (int n = 0; n < 4; n++) begin
            len = ($random(seed) & 63) + 1;
            send_frame((n % 2 == 0) ? eth_pkg::ETH_TYPE_IP : eth_pkg::ETH_TYPE_ARP, len, 0);
        end
        report_test("back-to-back traffic", mark);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/eth_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        fs,
    input  wire eth_pkg::ether_type_t  frame_type,
    input  wire eth_pkg::mac_addr_t    dst_mac,
    input  wire eth_pkg::mac_addr_t    src_mac,
    input  wire eth_pkg::ip_addr_t     src_ip,
    input  wire eth_pkg::ip_addr_t     dst_ip,
    input  wire eth_pkg::payload_len_t payload_len,
    input  wire                        wr_en,
    input  wire eth_pkg::buf_addr_t    wr_addr,
    input  wire eth_pkg::byte_t        wr_data,
    output wire                        fd,
    output wire                        gmii_tx_en,
    output wire eth_pkg::byte_t        gmii_txd
);

    wire                     fs_arp;
    wire                     fs_ip;
    wire                     fd_arp;
    wire                     fd_ip;
    wire                     tx_en;
    wire eth_pkg::byte_t     txd;
    wire eth_pkg::byte_t     arp_txd;
    wire eth_pkg::byte_t     ip_txd;
    wire eth_pkg::buf_addr_t rd_addr;
    wire eth_pkg::byte_t     rd_data;

    mac_tx mac_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .frame_type (frame_type),
        .dst_mac    (dst_mac),
        .src_mac    (src_mac),
        .fd_arp     (fd_arp),
        .fd_ip      (fd_ip),
        .arp_txd    (arp_txd),
        .ip_txd     (ip_txd),
        .fd         (fd),
        .fs_arp     (fs_arp),
        .fs_ip      (fs_ip),
        .tx_en      (tx_en),
        .txd        (txd)
    );

    arp_tx arp_tx_inst (
        .clk     (clk),
        .rst     (rst),
        .fs_arp  (fs_arp),
        .src_mac (src_mac),
        .src_ip  (src_ip),
        .dst_ip  (dst_ip),
        .fd_arp  (fd_arp),
        .arp_txd (arp_txd)
    );

    ip_tx ip_tx_inst (
        .clk         (clk),
        .rst         (rst),
        .fs_ip       (fs_ip),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .payload_len (payload_len),
        .rd_data     (rd_data),
        .fd_ip       (fd_ip),
        .ip_txd      (ip_txd),
        .rd_addr     (rd_addr)
    );

    payload_buf payload_buf_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    eth_fcs eth_fcs_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_en      (tx_en),
        .txd        (txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd)
    );

endmodule

`default_nettype wire

//--- rtl/mac_tx.sv
`timescale 1ns/10ps
`default_nettype none

module mac_tx (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       fs,
    input  wire eth_pkg::ether_type_t frame_type,
    input  wire eth_pkg::mac_addr_t   dst_mac,
    input  wire eth_pkg::mac_addr_t   src_mac,
    input  wire                       fd_arp,
    input  wire                       fd_ip,
    input  wire eth_pkg::byte_t       arp_txd,
    input  wire eth_pkg::byte_t       ip_txd,
    output logic                      fd,
    output logic                      fs_arp,
    output logic                      fs_ip,
    output logic                      tx_en,
    output eth_pkg::byte_t            txd
);

    eth_pkg::mac_state_t           state;
    eth_pkg::mac_state_t           next_state;
    logic [3:0]                    hdr_cnt;
    logic [4:0]                    gap_cnt;
    logic                          is_arp;
    logic                          gen_fd;
    eth_pkg::byte_t                gen_txd;
    eth_pkg::byte_t                hdr_byte;
    logic [8*eth_pkg::HDR_LEN-1:0] hdr_vec;

    assign is_arp  = (frame_type == eth_pkg::ETH_TYPE_ARP);   // anything else goes out as ip.
    assign gen_fd  = is_arp ? fd_arp : fd_ip;
    assign gen_txd = is_arp ? arp_txd : ip_txd;
    assign hdr_vec = {dst_mac, src_mac, frame_type};
    assign hdr_byte = hdr_vec[{4'(eth_pkg::HDR_LEN - 1) - hdr_cnt, 3'b000} +: 8];  // msb first.
    assign fd = (state == eth_pkg::DONE);

    always_comb begin
        next_state = state;
        case (state)
            eth_pkg::IDLE: next_state = eth_pkg::WAIT;
            eth_pkg::WAIT: if (fs) next_state = eth_pkg::HDR;
            eth_pkg::HDR: if (hdr_cnt == 4'(eth_pkg::HDR_LEN - 1)) next_state = eth_pkg::WORK;
            eth_pkg::WORK: if (gen_fd) next_state = eth_pkg::GAP;
            // the first gap cycle still carries the last byte.
            eth_pkg::GAP: if (gap_cnt == 5'(eth_pkg::IFG_CYCLES + 1)) next_state = eth_pkg::DONE;
            eth_pkg::DONE: if (!fs) next_state = eth_pkg::WAIT;
            default: next_state = eth_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= eth_pkg::IDLE;
            hdr_cnt <= 4'd0;
            gap_cnt <= 5'd0;
        end else begin
            state   <= next_state;
            hdr_cnt <= (state == eth_pkg::HDR) ? hdr_cnt + 4'd1 : 4'd0;
            gap_cnt <= (state == eth_pkg::GAP) ? gap_cnt + 5'd1 : 5'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_en <= 1'b0;
            txd   <= 8'h00;
        end else begin
            case (state)
                eth_pkg::HDR: begin
                    tx_en <= 1'b1;
                    txd   <= hdr_byte;
                end
                eth_pkg::WORK: begin
                    tx_en <= 1'b1;
                    txd   <= gen_txd;   // generator byte k in work cycle k.
                end
                default: begin
                    tx_en <= 1'b0;
                    txd   <= 8'h00;
                end
            endcase
        end
    end

    // payload start, high during header byte FS_MODE_HDR_BYTE.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_arp <= 1'b0;
            fs_ip  <= 1'b0;
        end else if (state == eth_pkg::DONE) begin
            fs_arp <= 1'b0;
            fs_ip  <= 1'b0;
        end else if (state == eth_pkg::HDR &&
                     hdr_cnt == 4'(eth_pkg::FS_MODE_HDR_BYTE - 1)) begin
            fs_arp <= is_arp;
            fs_ip  <= !is_arp;
        end
    end

    // the generator in use matches the frame type.
    one_generator: assert property (@(posedge clk) disable iff (rst)
        (fs_arp || fs_ip) |-> (fs_arp != fs_ip) && (fs_arp == is_arp));

    // only the first gap cycle still carries the last byte.
    quiet_gap: assert property (@(posedge clk) disable iff (rst)
        state == eth_pkg::GAP && gap_cnt != 5'd0 |-> !tx_en);

endmodule

`default_nettype wire

//--- rtl/ip_tx.sv
`timescale 1ns/10ps
`default_nettype none

module ip_tx (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        fs_ip,
    input  wire eth_pkg::ip_addr_t     src_ip,
    input  wire eth_pkg::ip_addr_t     dst_ip,
    input  wire eth_pkg::payload_len_t payload_len,
    input  wire eth_pkg::byte_t        rd_data,
    output logic                       fd_ip,
    output eth_pkg::byte_t             ip_txd,
    output eth_pkg::buf_addr_t         rd_addr
);

    logic [6:0]                       cnt;
    logic [6:0]                       cnt_end;
    logic [15:0]                      total_len;
    logic [15:0]                      ip_id;
    logic [19:0]                      sum_acc;   // wide enough for eight words.
    logic [16:0]                      fold1;
    logic [15:0]                      fold2;
    logic [4:0]                       hdr_idx;
    logic                             in_hdr;
    logic                             in_pay;
    logic [8*eth_pkg::IP_HDR_LEN-1:0] ip_hdr;

    assign total_len = 16'(eth_pkg::IP_HDR_LEN) + {9'd0, payload_len};
    assign cnt_end = 7'(eth_pkg::PAYLOAD_LEAD + eth_pkg::IP_HDR_LEN) + payload_len;
    assign in_hdr = fs_ip && cnt >= 7'(eth_pkg::PAYLOAD_LEAD) &&
                    cnt < 7'(eth_pkg::PAYLOAD_LEAD + eth_pkg::IP_HDR_LEN);
    assign in_pay = fs_ip && cnt >= 7'(eth_pkg::PAYLOAD_LEAD + eth_pkg::IP_HDR_LEN) &&
                    cnt < cnt_end;
    assign hdr_idx = 5'(cnt - 7'(eth_pkg::PAYLOAD_LEAD));

    // read address runs one cycle ahead of the payload byte.
    assign rd_addr = (cnt >= 7'(eth_pkg::PAYLOAD_LEAD + eth_pkg::IP_HDR_LEN - 1)) ?
                     6'(cnt - 7'(eth_pkg::PAYLOAD_LEAD + eth_pkg::IP_HDR_LEN - 1)) : 6'd0;

    assign fold1 = {1'b0, sum_acc[15:0]} + {13'd0, sum_acc[19:16]};
    assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

    assign ip_hdr = {
        8'h45,
        8'h00,
        total_len,
        ip_id,
        16'h0000,               // no fragments.
        eth_pkg::IP_TTL,
        eth_pkg::IP_PROTO,
        ~sum_acc[15:0],
        src_ip,
        dst_ip
    };

    assign ip_txd = in_hdr ? ip_hdr[{5'(eth_pkg::IP_HDR_LEN - 1) - hdr_idx, 3'b000} +: 8] :
                    in_pay ? rd_data : 8'h00;
    assign fd_ip = fs_ip && (cnt == cnt_end - 7'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= 7'd0;
            ip_id   <= 16'd0;
            sum_acc <= 20'd0;
        end else begin
            if (!fs_ip) begin
                cnt <= 7'd0;
            end else if (cnt != cnt_end) begin
                cnt <= cnt + 7'd1;
            end
            if (fd_ip) begin
                ip_id <= ip_id + 16'd1;   // once per frame.
            end
            // checksum is built in the lead cycles, before byte 10 goes out
            if (fs_ip) begin
                case (cnt)
                    7'd0: sum_acc <= 20'h04500 + {4'd0, total_len} + {4'd0, ip_id} +
                                     {4'd0, eth_pkg::IP_TTL, eth_pkg::IP_PROTO};
                    7'd1: sum_acc <= sum_acc + {4'd0, src_ip[31:16]} + {4'd0, src_ip[15:0]};
                    7'd2: sum_acc <= sum_acc + {4'd0, dst_ip[31:16]} + {4'd0, dst_ip[15:0]};
                    7'(eth_pkg::PAYLOAD_LEAD - 1): sum_acc <= {4'd0, fold2};
                    default: ;
                endcase
            end
        end
    end

    len_in_range: assert property (@(posedge clk) disable iff (rst)
        fs_ip |-> payload_len inside {[1:eth_pkg::PAYLOAD_MAX]});

endmodule

`default_nettype wire

//--- rtl/arp_tx.sv
`timescale 1ns/10ps
`default_nettype none

module arp_tx (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     fs_arp,
    input  wire eth_pkg::mac_addr_t src_mac,
    input  wire eth_pkg::ip_addr_t  src_ip,
    input  wire eth_pkg::ip_addr_t  dst_ip,
    output logic                    fd_arp,
    output eth_pkg::byte_t          arp_txd
);

    logic [5:0]                    cnt;   // lead cycles then byte index.
    logic [4:0]                    idx;
    logic                          active;
    logic [8*eth_pkg::ARP_LEN-1:0] arp_vec;

    assign arp_vec = {
        16'h0001,               // ethernet hardware.
        eth_pkg::ETH_TYPE_IP,
        8'd6,
        8'd4,
        16'h0001,               // request.
        src_mac,
        src_ip,
        48'h0,
        dst_ip
    };

    assign idx = 5'(cnt - 6'(eth_pkg::PAYLOAD_LEAD));
    assign active = fs_arp && cnt >= 6'(eth_pkg::PAYLOAD_LEAD) &&
                    cnt < 6'(eth_pkg::PAYLOAD_LEAD + eth_pkg::ARP_LEN);
    assign arp_txd = active ? arp_vec[{5'(eth_pkg::ARP_LEN - 1) - idx, 3'b000} +: 8] : 8'h00;
    assign fd_arp = fs_arp && (cnt == 6'(eth_pkg::PAYLOAD_LEAD + eth_pkg::ARP_LEN - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= 6'd0;
        end else if (!fs_arp) begin
            cnt <= 6'd0;
        end else if (cnt != 6'(eth_pkg::PAYLOAD_LEAD + eth_pkg::ARP_LEN)) begin
            cnt <= cnt + 6'd1;   // rests past the last byte.
        end
    end

endmodule

`default_nettype wire

//--- rtl/eth_fcs.sv
`timescale 1ns/10ps
`default_nettype none

module eth_fcs (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 tx_en,
    input  wire eth_pkg::byte_t txd,
    output logic                gmii_tx_en,
    output eth_pkg::byte_t      gmii_txd
);

    eth_pkg::crc_t crc;
    eth_pkg::crc_t crc_seed;
    eth_pkg::crc_t crc_next;
    eth_pkg::crc_t crc_fcs;
    eth_pkg::byte_t fcs_byte;
    logic          tx_en_d;
    logic          tail;
    logic [1:0]    tail_cnt;

    function automatic eth_pkg::crc_t crc_byte(input eth_pkg::crc_t c, input eth_pkg::byte_t d);
        eth_pkg::crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            r = (r >> 1) ^ (eth_pkg::CRC_POLY & {32{r[0] ^ d[i]}});   // lsb first.
        end
        return r;
    endfunction

    assign crc_seed = (tx_en && !tx_en_d) ? eth_pkg::CRC_INIT : crc;
    assign crc_next = crc_byte(crc_seed, txd);
    assign crc_fcs  = ~crc;
    assign fcs_byte = crc_fcs[{tail_cnt, 3'b000} +: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_en_d    <= 1'b0;
            crc        <= eth_pkg::CRC_INIT;
            tail       <= 1'b0;
            tail_cnt   <= 2'd0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
        end else begin
            tx_en_d <= tx_en;
            if (tx_en) begin
                gmii_tx_en <= 1'b1;
                gmii_txd   <= txd;
                crc        <= crc_next;
            end else if (tx_en_d || tail) begin
                gmii_tx_en <= 1'b1;   // fcs follows the last byte with no gap.
                gmii_txd   <= fcs_byte;
                tail       <= (tail_cnt != 2'd3);
                tail_cnt   <= tail_cnt + 2'd1;
            end else begin
                gmii_tx_en <= 1'b0;
                gmii_txd   <= 8'h00;
            end
        end
    end

    tail_not_cut: assert property (@(posedge clk) disable iff (rst)
        $fell(tx_en) |-> !tx_en [*4]);

endmodule

`default_nettype wire

//--- rtl/payload_buf.sv
`timescale 1ns/10ps
`default_nettype none

module payload_buf (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_en,
    input  wire eth_pkg::buf_addr_t wr_addr,
    input  wire eth_pkg::byte_t     wr_data,
    input  wire eth_pkg::buf_addr_t rd_addr,
    output eth_pkg::byte_t          rd_data
);

    eth_pkg::byte_t mem [0:eth_pkg::PAYLOAD_MAX-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= 8'h00;
        end else begin
            rd_data <= mem[rd_addr];   // one cycle read latency.
        end
    end

endmodule

`default_nettype wire

//--- rtl/eth_pkg.sv
`default_nettype none

package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [6:0]  payload_len_t;   // 1 to PAYLOAD_MAX.
    typedef logic [5:0]  buf_addr_t;
    typedef logic [31:0] crc_t;

    localparam ether_type_t ETH_TYPE_IP  = 16'h0800;
    localparam ether_type_t ETH_TYPE_ARP = 16'h0806;

    localparam int HDR_LEN     = 14;
    localparam int ARP_LEN     = 28;
    localparam int IP_HDR_LEN  = 20;
    localparam int PAYLOAD_MAX = 64;

    localparam int PAYLOAD_LEAD     = 4;    // fs_arp/fs_ip high to first payload byte.
    localparam int FS_MODE_HDR_BYTE = 10;   // header byte where the payload start goes high.
    localparam int IFG_CYCLES       = 16;   // 4 fcs cycles plus a 12-byte gap.

    localparam byte_t IP_TTL   = 8'd64;
    localparam byte_t IP_PROTO = 8'hFD;

    localparam crc_t CRC_POLY = 32'hEDB88320;   // reflected.
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        HDR,
        WORK,
        GAP,
        DONE
    } mac_state_t;

endpackage

`default_nettype wire
